//--- Bender.yml
package:
  name: lane_deskew

sources:
  - src/lane_deskew_pkg.sv
  - src/lane_start_detect.sv
  - src/word_packer.sv
  - src/lane_elastic_buffer.sv
  - src/release_ctrl.sv
  - src/lane_deskew_top.sv
  - target: test
    files:
      - dv/lane_deskew_props.sv
      - dv/lane_deskew_checker.sv
      - dv/tb_lane_deskew.sv

//--- dv/lane_deskew_checker.sv
// Reference model of the deskew stage for the testbench.
// Samples the lane inputs and DUT outputs on the rising edge and compares
// the released level, the output strobe, the aligned data and the error flags.

`timescale 1ns/1ps

module lane_deskew_checker (
  input  logic                        clk,
  input  logic                        rst_n,
  input  lane_deskew_pkg::lanes_in_t  lane_in,
  input  lane_deskew_pkg::dev_out_t   dev_out,
  input  logic                        released,
  input  lane_deskew_pkg::lane_mask_t lane_error,
  output int                          err_count,
  output int                          check_count
);

  lane_deskew_pkg::lane_word_t words [lane_deskew_pkg::num_lanes][$];  // after first marker
  lane_deskew_pkg::lane_mask_t seen;
  lane_deskew_pkg::lane_mask_t exp_err;
  int                          pos [lane_deskew_pkg::num_lanes];
  int                          cyc;
  int                          last_mark = -1;  // cycle of the last lane's first marker
  int                          errors = 0;
  int                          checks = 0;

  assign err_count   = errors;
  assign check_count = checks;

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
    end
  endtask

  //////////////////////////////
  // per-cycle model and compare
  //////////////////////////////
  always @(posedge clk) begin
    int since;
    int i;
    logic exp_rel;
    logic exp_valid;
    lane_deskew_pkg::dev_word_t exp_word;
    if (!rst_n) begin
      for (i = 0; i < lane_deskew_pkg::num_lanes; i++) begin
        words[i].delete();
        pos[i] = 0;
      end
      seen      = '0;
      exp_err   = '0;
      cyc       = 0;
      last_mark = -1;
    end else begin
      since     = (last_mark < 0) ? -1 : cyc - last_mark;
      exp_rel   = (since >= lane_deskew_pkg::release_delay + 2);
      exp_valid = (since >= lane_deskew_pkg::release_delay + 3) &&
                  ((since - lane_deskew_pkg::release_delay - 3) % 2 == 0);
      compare("released", exp_rel, released);
      compare("dev_out.valid", exp_valid, dev_out.valid);
      compare("lane_error", exp_err, lane_error);
      if (exp_valid && dev_out.valid) begin
        for (i = 0; i < lane_deskew_pkg::num_lanes; i++) begin
          if (words[i].size() < 2) begin
            errors++;
            $display("lane %0d produced output before two of its words had arrived", i);
          end else begin
            exp_word = {words[i][1], words[i][0]};  // earlier word low
            void'(words[i].pop_front());
            void'(words[i].pop_front());
            compare($sformatf("dev_out.data[%0d]", i), exp_word, dev_out.data[i]);
          end
        end
      end
      // fold in this cycle's lane words
      for (i = 0; i < lane_deskew_pkg::num_lanes; i++) begin
        if (!seen[i]) begin
          if (lane_in[i].marker) begin
            seen[i] = 1'b1;
            pos[i]  = 1;
          end
        end else begin
          if (lane_in[i].marker != (pos[i] == 0)) begin
            exp_err[i] = 1'b1;
          end
          pos[i] = (pos[i] + 1) % lane_deskew_pkg::mf_len;
          words[i].push_back(lane_in[i].data);
        end
      end
      if (&seen && last_mark < 0) begin
        last_mark = cyc;
      end
      cyc++;
    end
  end

endmodule

//--- dv/lane_deskew_props.sv
// Concurrent properties for the release controller.
// Bound into every release_ctrl instance.

`timescale 1ns/1ps

module lane_deskew_props (
  input logic clk,
  input logic rst_n,
  input logic do_release_n,
  input logic read_tick
);

  int fail_count = 0;  // failed assertions so far

  // reads only after release
  a_tick_after_release : assert property (
    @(posedge clk) disable iff (!rst_n) read_tick |-> !do_release_n
  ) else begin
    $error("read tick seen while the buffers are still held");
    fail_count++;
  end

  // once released, held released until reset
  a_release_sticky : assert property (
    @(posedge clk) disable iff (!rst_n) !do_release_n |=> !do_release_n
  ) else begin
    $error("release was withdrawn without a reset");
    fail_count++;
  end

  // one read per packed pair
  a_tick_spacing : assert property (
    @(posedge clk) disable iff (!rst_n) read_tick |=> !read_tick
  ) else begin
    $error("read tick high in two consecutive cycles");
    fail_count++;
  end

endmodule

bind release_ctrl lane_deskew_props u_props (
  .clk          (clk),
  .rst_n        (rst_n),
  .do_release_n (do_release_n),
  .read_tick    (read_tick)
);

//--- dv/tb_lane_deskew.sv
// Testbench for the lane deskew top level.
// Three runs with random lane skews and data; the last run misplaces one
// marker. A separate checker compares the DUT against a reference model.

`timescale 1ns/1ps

module tb_lane_deskew;

  localparam int clk_period   = 40;
  localparam int reset_cycles = 5;
  localparam int num_runs     = 3;
  localparam int run_mfs      = 12;
  localparam int lead_words   = 4;  // idle words before the earliest marker
  localparam int max_skew     = 7;
  localparam int run_words    = lead_words + max_skew + run_mfs * lane_deskew_pkg::mf_len;
  localparam int watchdog_ns  =
    (num_runs * (reset_cycles + run_mfs * lane_deskew_pkg::mf_len + 64) + 200) * clk_period;

  logic                        clk;
  logic                        rst_n;
  lane_deskew_pkg::lanes_in_t  lane_in;
  lane_deskew_pkg::dev_out_t   dev_out;
  logic                        released;
  lane_deskew_pkg::lane_mask_t lane_error;
  int                          err_count;
  int                          check_count;
  int unsigned                 rng_state;

  lane_deskew_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .lane_in    (lane_in),
    .dev_out    (dev_out),
    .released   (released),
    .lane_error (lane_error)
  );

  lane_deskew_checker u_check (
    .clk         (clk),
    .rst_n       (rst_n),
    .lane_in     (lane_in),
    .dev_out     (dev_out),
    .released    (released),
    .lane_error  (lane_error),
    .err_count   (err_count),
    .check_count (check_count)
  );

  always #(clk_period / 2) clk = ~clk;

  function automatic int unsigned next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic apply_reset();
    @(negedge clk);
    rst_n   = 1'b0;
    lane_in = '0;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // markers every mf_len words from each lane's skewed start
  task automatic drive_run(input bit with_fault);
    int   start [lane_deskew_pkg::num_lanes];
    int   bad_lane;
    int   rel;
    int   i;
    int   n;
    logic marker;
    bad_lane = -1;
    for (i = 0; i < lane_deskew_pkg::num_lanes; i++) begin
      start[i] = lead_words + int'((next_rand() >> 16) % (max_skew + 1));
    end
    if (with_fault) begin
      bad_lane = int'((next_rand() >> 16) % lane_deskew_pkg::num_lanes);
    end
    for (n = 0; n < run_words; n++) begin
      @(negedge clk);
      for (i = 0; i < lane_deskew_pkg::num_lanes; i++) begin
        rel    = n - start[i];
        marker = (rel >= 0) && (rel % lane_deskew_pkg::mf_len == 0);
        if (i == bad_lane) begin
          // fifth multiframe marker comes one word early
          if (rel == 4 * lane_deskew_pkg::mf_len) marker = 1'b0;
          if (rel == 4 * lane_deskew_pkg::mf_len - 1) marker = 1'b1;
        end
        lane_in[i].marker = marker;
        lane_in[i].data   = next_rand();
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    int r;
    int assert_fails;
    clk       = 1'b0;
    rst_n     = 1'b0;
    lane_in   = '0;
    rng_state = 14920;
    for (r = 0; r < num_runs; r++) begin
      apply_reset();
      drive_run(r == num_runs - 1);
    end
    repeat (4) @(negedge clk);
    assert_fails = u_dut.u_release.u_props.fail_count;
    $display("checks: %0d, mismatches: %0d, assertion failures: %0d",
             check_count, err_count, assert_fails);
    if (err_count == 0 && assert_fails == 0 && check_count > 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- project.f
src/lane_deskew_pkg.sv
src/lane_start_detect.sv
src/word_packer.sv
src/lane_elastic_buffer.sv
src/release_ctrl.sv
src/lane_deskew_top.sv
dv/lane_deskew_props.sv
dv/lane_deskew_checker.sv
dv/tb_lane_deskew.sv

//--- src/lane_deskew_pkg.sv
// Shared constants and types for the lane deskew stage.
// Every design file refers to these by scoped name.

package lane_deskew_pkg;

  //////////////////////////////
  // link geometry
  //////////////////////////////
  localparam int num_lanes     = 4;
  localparam int lane_width    = 32;
  localparam int dev_width     = 64;   // two lane words per entry
  localparam int mf_len        = 32;   // lane words between markers
  localparam int release_delay = 8;    // cycles from all ready to release
  localparam int buf_depth     = 16;   // entries per lane buffer

  //////////////////////////////
  // vector types
  //////////////////////////////
  typedef logic [lane_width-1:0]         lane_word_t;
  typedef logic [dev_width-1:0]          dev_word_t;  // earlier word in low half
  typedef logic [$clog2(buf_depth)-1:0]  buf_addr_t;
  typedef logic [$clog2(mf_len)-1:0]     mf_count_t;
  typedef logic [num_lanes-1:0]          lane_mask_t;

  //////////////////////////////
  // bundles
  //////////////////////////////
  typedef struct packed {
    logic       marker;  // start of multiframe
    lane_word_t data;
  } lane_in_t;

  typedef lane_in_t [num_lanes-1:0] lanes_in_t;

  typedef struct packed {
    logic                        valid;
    dev_word_t [num_lanes-1:0]   data;  // one aligned word per lane
  } dev_out_t;

  // release controller FSM
  typedef enum logic [1:0] {
    wait_lanes,
    delay,
    run
  } rel_state_t;

endpackage

//--- src/lane_deskew_top.sv
// Receive-side lane deskew, top level.
// Four lanes are buffered from their own marker and read out together,
// so each output word set comes from the same multiframe position.

`timescale 1ns/1ps

module lane_deskew_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  lane_deskew_pkg::lanes_in_t  lane_in,
  output lane_deskew_pkg::dev_out_t   dev_out,
  output logic                        released,
  output lane_deskew_pkg::lane_mask_t lane_error
);

  lane_deskew_pkg::lane_mask_t lane_ready_n;
  lane_deskew_pkg::lane_mask_t rd_valid;   // all lanes read in lockstep
  logic                        do_release_n;
  logic                        read_tick;

  //////////////////////////////
  // per-lane path
  //////////////////////////////
  for (genvar i = 0; i < lane_deskew_pkg::num_lanes; i++) begin : g_lane
    lane_start_detect u_detect (
      .clk     (clk),
      .rst_n   (rst_n),
      .lane    (lane_in[i]),
      .ready_n (lane_ready_n[i]),
      .error   (lane_error[i])
    );

    lane_elastic_buffer u_buf (
      .clk          (clk),
      .rst_n        (rst_n),
      .ready_n      (lane_ready_n[i]),
      .do_release_n (do_release_n),
      .read_tick    (read_tick),
      .data         (lane_in[i].data),
      .rd_data      (dev_out.data[i]),
      .rd_valid     (rd_valid[i])
    );
  end

  //////////////////////////////
  // shared release
  //////////////////////////////
  release_ctrl u_release (
    .clk          (clk),
    .rst_n        (rst_n),
    .lane_ready_n (lane_ready_n),
    .do_release_n (do_release_n),
    .read_tick    (read_tick)
  );

  assign dev_out.valid = rd_valid[0];
  assign released      = ~do_release_n;

endmodule

//--- src/lane_elastic_buffer.sv
// Elastic buffer for one lane.
// Packed entries are written from the lane's start onwards and read out
// on the shared read tick once the controller releases all lanes.

`timescale 1ns/1ps

module lane_elastic_buffer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ready_n,
  input  logic                        do_release_n,
  input  logic                        read_tick,
  input  lane_deskew_pkg::lane_word_t data,
  output lane_deskew_pkg::dev_word_t  rd_data,
  output logic                        rd_valid
);

  lane_deskew_pkg::dev_word_t entry;
  logic                       wr_strobe;
  lane_deskew_pkg::buf_addr_t wr_addr;
  lane_deskew_pkg::buf_addr_t rd_addr;
  logic                       rd_en;

  lane_deskew_pkg::dev_word_t mem [lane_deskew_pkg::buf_depth];

  //////////////////////////////
  // write side
  //////////////////////////////
  word_packer u_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ready_n   (ready_n),
    .data      (data),
    .entry     (entry),
    .wr_strobe (wr_strobe)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (ready_n) begin
      wr_addr <= '0;  // held until the lane starts
    end else if (wr_strobe) begin
      wr_addr <= wr_addr + 1'b1;  // wraps at buf_depth
    end
  end

  always_ff @(posedge clk) begin
    if (wr_strobe) begin
      mem[wr_addr] <= entry;
    end
  end

  //////////////////////////////
  // read side
  //////////////////////////////
  assign rd_en = read_tick & ~do_release_n;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr  <= '0;
      rd_valid <= 1'b0;
    end else if (do_release_n) begin
      rd_addr  <= '0;  // parked until release
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
      if (rd_en) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // data follows the tick by one cycle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

//--- src/lane_start_detect.sv
// Per-lane start-of-multiframe detection.
// Lowers ready_n after the first marker and flags marker spacing errors.

`timescale 1ns/1ps

module lane_start_detect (
  input  logic                      clk,
  input  logic                      rst_n,
  input  lane_deskew_pkg::lane_in_t lane,
  output logic                      ready_n,
  output logic                      error
);

  logic                        seen;      // first marker received
  lane_deskew_pkg::mf_count_t  pos;       // position of the current word
  logic                        exp_marker;
  lane_deskew_pkg::mf_count_t  pos_next;

  assign exp_marker = (pos == '0);
  assign pos_next   = (pos == lane_deskew_pkg::mf_count_t'(lane_deskew_pkg::mf_len - 1)) ?
                      '0 : pos + 1'b1;

  //////////////////////////////
  // lock onto first marker
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen <= 1'b0;
      pos  <= '0;
    end else if (!seen) begin
      if (lane.marker) begin
        seen <= 1'b1;
        pos  <= lane_deskew_pkg::mf_count_t'(1);  // marker itself was position 0
      end
    end else begin
      pos <= pos_next;
    end
  end

  assign ready_n = ~seen;

  //////////////////////////////
  // spacing monitor
  //////////////////////////////
  // once locked, a marker must show up at position 0 and nowhere else
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error <= 1'b0;
    end else if (seen && (lane.marker != exp_marker)) begin
      error <= 1'b1;  // sticky until reset
    end
  end

endmodule

//--- src/release_ctrl.sv
// Joint release of all lane buffers.
// Waits for every lane to start, counts a fixed delay, then releases
// the buffers and paces their reads on every second cycle.

`timescale 1ns/1ps

module release_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  lane_deskew_pkg::lane_mask_t lane_ready_n,
  output logic                        do_release_n,
  output logic                        read_tick
);

  lane_deskew_pkg::rel_state_t                      state;
  logic [$clog2(lane_deskew_pkg::release_delay+1)-1:0] delay_cnt;
  logic                                             rd_phase;  // high on idle half
  logic                                             all_ready;
  logic                                             delay_done;

  assign all_ready  = ~|lane_ready_n;
  assign delay_done = (delay_cnt ==
                       $bits(delay_cnt)'(lane_deskew_pkg::release_delay - 1));

  //////////////////////////////
  // state machine
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= lane_deskew_pkg::wait_lanes;
      delay_cnt <= '0;
      rd_phase  <= 1'b0;
    end else begin
      case (state)
        lane_deskew_pkg::wait_lanes: begin
          delay_cnt <= '0;
          if (all_ready) begin
            state <= lane_deskew_pkg::delay;
          end
        end
        lane_deskew_pkg::delay: begin
          if (delay_done) begin
            state <= lane_deskew_pkg::run;
          end else begin
            delay_cnt <= delay_cnt + 1'b1;
          end
        end
        lane_deskew_pkg::run: begin
          rd_phase <= ~rd_phase;  // one read per packed pair
        end
        default: begin
          state <= lane_deskew_pkg::wait_lanes;
        end
      endcase
    end
  end

  assign do_release_n = (state != lane_deskew_pkg::run);
  assign read_tick    = (state == lane_deskew_pkg::run) & ~rd_phase;

endmodule

//--- src/word_packer.sv
// Pairs consecutive lane words into one device word.
// The pairing restarts at the first word after the lane's marker.

`timescale 1ns/1ps

module word_packer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        ready_n,
  input  lane_deskew_pkg::lane_word_t data,
  output lane_deskew_pkg::dev_word_t  entry,
  output logic                        wr_strobe
);

  logic                        phase;  // high when the low half is held
  lane_deskew_pkg::lane_word_t hold;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= 1'b0;
      wr_strobe <= 1'b0;
    end else if (ready_n) begin
      phase     <= 1'b0;  // lane not started yet
      wr_strobe <= 1'b0;
    end else begin
      phase     <= ~phase;
      wr_strobe <= phase;  // pair completes on the high word
    end
  end

  // payload path
  always_ff @(posedge clk) begin
    if (!ready_n) begin
      if (!phase) begin
        hold <= data;
      end else begin
        entry <= {data, hold};  // earlier word in the low half
      end
    end
  end

endmodule
